// ==== axi_demux_pkg.sv ====
//--------------------------------------------------------------------------
// AXI read demux shared definitions.
// Field widths, read request and beat payloads, response codes and the
// R arbiter state encoding.
//--------------------------------------------------------------------------
`default_nettype none

package axi_demux_pkg;

  // AXI field widths.
  localparam int addr_width = 12;
  localparam int data_width = 32;
  localparam int len_width = 8;
  localparam int size_width = 3;
  localparam int burst_width = 2;
  localparam int resp_width = 2;

  // Read response codes.
  typedef enum logic [resp_width-1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_e;

  // AR payload without the ID, 25 bits.
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [len_width-1:0] len;
    logic [size_width-1:0] size;
    logic [burst_width-1:0] burst;
  } ar_req_t;

  // One R beat without the ID, 35 bits.
  typedef struct packed {
    logic [data_width-1:0] data;
    axi_resp_e resp;
    logic last;
  } r_beat_t;

  // R arbiter holds a subordinate until its burst ends.
  typedef enum logic {
    arb_idle   = 1'b0,
    arb_locked = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

// ==== ar_chan_if.sv ====
//--------------------------------------------------------------------------
// AR channel bundle between the router slots and a downstream port.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface ar_chan_if
  import axi_demux_pkg::*;
#(
  parameter int id_width = 2
) ();

  logic valid;
  logic ready;
  logic [id_width-1:0] id;
  ar_req_t req;

  // Router slot side.
  modport src (
    output valid,
    output id,
    output req,
    input  ready
  );

  // Downstream port side.
  modport dst (
    input  valid,
    input  id,
    input  req,
    output ready
  );

endinterface

`default_nettype wire

// ==== r_chan_if.sv ====
//--------------------------------------------------------------------------
// R channel bundle between a downstream port and the R arbiter.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface r_chan_if
  import axi_demux_pkg::*;
#(
  parameter int id_width = 2
) ();

  logic valid;
  logic ready;
  logic [id_width-1:0] id;
  r_beat_t beat;

  // Downstream port side.
  modport src (
    output valid,
    output id,
    output beat,
    input  ready
  );

  // Arbiter side.
  modport dst (
    input  valid,
    input  id,
    input  beat,
    output ready
  );

endinterface

`default_nettype wire

// ==== id_order_tracker.sv ====
//--------------------------------------------------------------------------
// Per-ID read ordering tracker.
// Counts outstanding reads per ID and remembers which subordinate owns
// them, so a new read is only granted where its responses stay in order.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module id_order_tracker #(
  parameter int num_subs = 2,
  parameter int id_width = 2,
  parameter int max_outstanding = 3,
  localparam int sub_width = (num_subs > 1) ? $clog2(num_subs) : 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic [id_width-1:0] id,
  input  logic [sub_width-1:0] sub_select,
  output logic grant,
  input  logic alloc,
  input  logic burst_done,
  input  logic [id_width-1:0] done_id
);

  localparam int num_ids = 1 << id_width;
  localparam int cnt_width = $clog2(max_outstanding + 1);

  logic [cnt_width-1:0] count [num_ids];
  logic [cnt_width-1:0] count_next [num_ids];
  logic [sub_width-1:0] owner [num_ids];

  // A free ID may go anywhere.
  // A busy ID may only stack more reads on its owner, up to the cap.
  always_comb begin
    grant = 1'b0;
    if (count[id] == '0) begin
      grant = 1'b1;
    end else if (owner[id] == sub_select &&
                 count[id] < cnt_width'(max_outstanding)) begin
      grant = 1'b1;
    end
  end

  // Allocation and completion can hit the same ID in one cycle.
  always_comb begin
    for (int i = 0; i < num_ids; i++) begin
      count_next[i] = count[i];
      if (alloc && id == id_width'(i)) begin
        count_next[i] = count_next[i] + 1'b1;
      end
      if (burst_done && done_id == id_width'(i)) begin
        count_next[i] = count_next[i] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_ids; i++) begin
        count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_ids; i++) begin
        count[i] <= count_next[i];
      end
    end
  end

  // Owner is only looked at while the count is nonzero.
  always_ff @(posedge clk) begin
    if (alloc) begin
      owner[id] <= sub_select;
    end
  end

endmodule

`default_nettype wire

// ==== ar_router.sv ====
//--------------------------------------------------------------------------
// AR router.
// Steers the upstream AR into a one-entry registered slot per subordinate.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ar_router
  import axi_demux_pkg::*;
#(
  parameter int num_subs = 2,
  parameter int id_width = 2,
  localparam int sub_width = (num_subs > 1) ? $clog2(num_subs) : 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic up_valid,
  output logic up_ready,
  input  logic [id_width-1:0] up_id,
  input  ar_req_t up_req,
  input  logic [sub_width-1:0] sub_select,
  input  logic grant,
  output logic alloc,
  ar_chan_if.src down [num_subs]
);

  logic [num_subs-1:0] slot_valid;
  logic [num_subs-1:0] slot_ready;
  logic target_free;

  // The target slot can take a request when empty or draining this cycle.
  always_comb begin
    target_free = 1'b0;
    if (int'(sub_select) < num_subs) begin
      target_free = !slot_valid[sub_select] || slot_ready[sub_select];
    end
  end

  assign up_ready = grant && target_free;
  assign alloc = up_valid && up_ready;

  for (genvar i = 0; i < num_subs; i++) begin : gen_slot
    logic load;
    logic valid_q;
    logic [id_width-1:0] id_q;
    ar_req_t req_q;

    assign load = alloc && (sub_select == sub_width'(i));
    assign slot_ready[i] = down[i].ready;
    assign slot_valid[i] = valid_q;

    // A load wins over a drain in the same cycle.
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
      end else if (load) begin
        valid_q <= 1'b1;
      end else if (slot_ready[i]) begin
        valid_q <= 1'b0;
      end
    end

    always_ff @(posedge clk) begin
      if (load) begin
        id_q <= up_id;
        req_q <= up_req;
      end
    end

    assign down[i].valid = valid_q;
    assign down[i].id = id_q;
    assign down[i].req = req_q;
  end

endmodule

`default_nettype wire

// ==== r_burst_arbiter.sv ====
//--------------------------------------------------------------------------
// R burst arbiter.
// Round-robin merge of subordinate R channels onto one upstream R channel.
// A granted burst keeps the channel until its last beat, no interleaving.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module r_burst_arbiter
  import axi_demux_pkg::*;
#(
  parameter int num_subs = 2,
  parameter int id_width = 2,
  localparam int sub_width = (num_subs > 1) ? $clog2(num_subs) : 1
) (
  input  logic clk,
  input  logic rst_n,
  r_chan_if.dst sub [num_subs],
  output logic up_valid,
  input  logic up_ready,
  output logic [id_width-1:0] up_id,
  output r_beat_t up_beat,
  output logic burst_done,
  output logic [id_width-1:0] done_id
);

  arb_state_e state;
  logic [sub_width-1:0] rr_ptr;
  logic [sub_width-1:0] lock_sub;
  logic [sub_width-1:0] pick;
  logic pick_found;
  logic [sub_width-1:0] sel;
  logic [sub_width-1:0] next_ptr;
  logic [num_subs-1:0] req_valid;
  logic [id_width-1:0] req_id [num_subs];
  r_beat_t req_beat [num_subs];
  logic up_fire;

  for (genvar i = 0; i < num_subs; i++) begin : gen_sub
    assign req_valid[i] = sub[i].valid;
    assign req_id[i] = sub[i].id;
    assign req_beat[i] = sub[i].beat;
    assign sub[i].ready = up_ready && (sel == sub_width'(i));
  end

  // First requester at or after the pointer.
  always_comb begin
    int idx;
    pick = rr_ptr;
    pick_found = 1'b0;
    for (int k = 0; k < num_subs; k++) begin
      idx = (int'(rr_ptr) + k) % num_subs;
      if (!pick_found && req_valid[idx]) begin
        pick = sub_width'(idx);
        pick_found = 1'b1;
      end
    end
  end

  assign sel = (state == arb_locked) ? lock_sub : pick;
  assign next_ptr = (sel == sub_width'(num_subs - 1)) ? '0 : sel + 1'b1;

  assign up_valid = req_valid[sel];
  assign up_id = req_id[sel];
  assign up_beat = req_beat[sel];
  assign up_fire = up_valid && up_ready;

  assign burst_done = up_fire && up_beat.last;
  assign done_id = up_id;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= arb_idle;
      rr_ptr <= '0;
      lock_sub <= '0;
    end else if (up_fire) begin
      if (up_beat.last) begin
        state <= arb_idle;
        rr_ptr <= next_ptr;
      end else begin
        // Hold this subordinate for the rest of the burst.
        state <= arb_locked;
        lock_sub <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// ==== axi_read_demux.sv ====
//--------------------------------------------------------------------------
// AXI read demux top level.
// One manager reads from several subordinates chosen by ar_sub_select,
// with per-ID ordering and a single merged R channel.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_read_demux
  import axi_demux_pkg::*;
#(
  parameter int num_subs = 2,
  parameter int id_width = 2,
  parameter int max_outstanding = 3,
  localparam int sub_width = (num_subs > 1) ? $clog2(num_subs) : 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic [sub_width-1:0] ar_sub_select,
  input  logic [addr_width-1:0] araddr,
  input  logic [id_width-1:0] arid,
  input  logic [len_width-1:0] arlen,
  input  logic [size_width-1:0] arsize,
  input  logic [burst_width-1:0] arburst,
  input  logic arvalid,
  output logic arready,
  output logic [id_width-1:0] rid,
  output logic [data_width-1:0] rdata,
  output logic [resp_width-1:0] rresp,
  output logic rlast,
  output logic rvalid,
  input  logic rready,
  output logic [num_subs-1:0][addr_width-1:0] downstream_araddr,
  output logic [num_subs-1:0][id_width-1:0] downstream_arid,
  output logic [num_subs-1:0][len_width-1:0] downstream_arlen,
  output logic [num_subs-1:0][size_width-1:0] downstream_arsize,
  output logic [num_subs-1:0][burst_width-1:0] downstream_arburst,
  output logic [num_subs-1:0] downstream_arvalid,
  input  logic [num_subs-1:0] downstream_arready,
  input  logic [num_subs-1:0][id_width-1:0] downstream_rid,
  input  logic [num_subs-1:0][data_width-1:0] downstream_rdata,
  input  logic [num_subs-1:0][resp_width-1:0] downstream_rresp,
  input  logic [num_subs-1:0] downstream_rlast,
  input  logic [num_subs-1:0] downstream_rvalid,
  output logic [num_subs-1:0] downstream_rready
);

  ar_req_t up_req;
  r_beat_t up_beat;
  logic grant;
  logic alloc;
  logic burst_done;
  logic [id_width-1:0] done_id;

  ar_chan_if #(.id_width(id_width)) ar_if [num_subs] ();
  r_chan_if #(.id_width(id_width)) r_if [num_subs] ();

  assign up_req = '{addr: araddr, len: arlen, size: arsize, burst: arburst};

  id_order_tracker #(
    .num_subs(num_subs),
    .id_width(id_width),
    .max_outstanding(max_outstanding)
  ) id_order_tracker_i (
    .clk,
    .rst_n,
    .id(arid),
    .sub_select(ar_sub_select),
    .grant,
    .alloc,
    .burst_done,
    .done_id
  );

  ar_router #(
    .num_subs(num_subs),
    .id_width(id_width)
  ) ar_router_i (
    .clk,
    .rst_n,
    .up_valid(arvalid),
    .up_ready(arready),
    .up_id(arid),
    .up_req,
    .sub_select(ar_sub_select),
    .grant,
    .alloc,
    .down(ar_if)
  );

  r_burst_arbiter #(
    .num_subs(num_subs),
    .id_width(id_width)
  ) r_burst_arbiter_i (
    .clk,
    .rst_n,
    .sub(r_if),
    .up_valid(rvalid),
    .up_ready(rready),
    .up_id(rid),
    .up_beat,
    .burst_done,
    .done_id
  );

  assign rdata = up_beat.data;
  assign rresp = up_beat.resp;
  assign rlast = up_beat.last;

  // Per-subordinate port wiring.
  for (genvar i = 0; i < num_subs; i++) begin : gen_sub_ports
    assign downstream_arvalid[i] = ar_if[i].valid;
    assign downstream_arid[i] = ar_if[i].id;
    assign downstream_araddr[i] = ar_if[i].req.addr;
    assign downstream_arlen[i] = ar_if[i].req.len;
    assign downstream_arsize[i] = ar_if[i].req.size;
    assign downstream_arburst[i] = ar_if[i].req.burst;
    assign ar_if[i].ready = downstream_arready[i];

    assign r_if[i].valid = downstream_rvalid[i];
    assign r_if[i].id = downstream_rid[i];
    assign r_if[i].beat = '{
      data: downstream_rdata[i],
      resp: axi_resp_e'(downstream_rresp[i]),
      last: downstream_rlast[i]
    };
    assign downstream_rready[i] = r_if[i].ready;
  end

endmodule

`default_nettype wire

// ==== tb_axi_read_demux.sv ====
//----------------------------------------------------------------------------
// Testbench for the AXI read demux.
// Models two subordinates and drives directed and random reads. Checks AR
// forwarding, burst data, per-ID ordering and completion.
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_axi_read_demux
  import axi_demux_pkg::*;
();

  localparam int num_subs = 2;
  localparam int id_width = 2;
  localparam int max_outstanding = 3;
  localparam int num_ids = 1 << id_width;
  localparam int timeout_cycles = 2000;
  localparam logic [31:0] seed = 32'h974870fe;

  logic clk;
  logic rst_n;
  logic [0:0] ar_sub_select;
  logic [addr_width-1:0] araddr;
  logic [id_width-1:0] arid;
  logic [len_width-1:0] arlen;
  logic [size_width-1:0] arsize;
  logic [burst_width-1:0] arburst;
  logic arvalid;
  logic arready;
  logic [id_width-1:0] rid;
  logic [data_width-1:0] rdata;
  logic [resp_width-1:0] rresp;
  logic rlast;
  logic rvalid;
  logic rready;
  logic [num_subs-1:0][addr_width-1:0] downstream_araddr;
  logic [num_subs-1:0][id_width-1:0] downstream_arid;
  logic [num_subs-1:0][len_width-1:0] downstream_arlen;
  logic [num_subs-1:0][size_width-1:0] downstream_arsize;
  logic [num_subs-1:0][burst_width-1:0] downstream_arburst;
  logic [num_subs-1:0] downstream_arvalid;
  logic [num_subs-1:0] downstream_arready;
  logic [num_subs-1:0][id_width-1:0] downstream_rid;
  logic [num_subs-1:0][data_width-1:0] downstream_rdata;
  logic [num_subs-1:0][resp_width-1:0] downstream_rresp;
  logic [num_subs-1:0] downstream_rlast;
  logic [num_subs-1:0] downstream_rvalid;
  logic [num_subs-1:0] downstream_rready;

  // Subordinate models hold {id, len, addr} per accepted AR.
  logic [num_subs-1:0] hold;
  logic ar_gaps;
  logic [31:0] sub_q [num_subs][$];
  int beat_idx [num_subs];

  // Scoreboard state.
  logic [31:0] fwd_q [num_subs][$];
  logic [31:0] exp_q [num_ids][$];
  int outstanding [num_ids];
  logic [0:0] owner [num_ids];
  int issued;
  int returned;
  int beat_cnt;
  int pend_sub;
  logic ar_pending;
  logic in_burst;
  logic [id_width-1:0] burst_id;
  logic [31:0] pend_entry;
  logic [31:0] ready_lcg;
  logic [31:0] traffic_lcg;

  axi_read_demux #(
    .num_subs(num_subs),
    .id_width(id_width),
    .max_outstanding(max_outstanding)
  ) axi_read_demux_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] ar_entry(input logic [id_width-1:0] id,
                                           input logic [addr_width-1:0] addr,
                                           input logic [len_width-1:0] len,
                                           input logic [size_width-1:0] size,
                                           input logic [burst_width-1:0] burst);
    return 32'({id, addr, len, size, burst});
  endfunction

  task automatic report_error(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic timeout_abort(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // Scoreboard sampled at the rising edge.
  always @(posedge clk) begin
    logic [31:0] entry;
    if (!rst_n) begin
      for (int i = 0; i < num_ids; i++) begin
        exp_q[i].delete();
        outstanding[i] = 0;
      end
      for (int s = 0; s < num_subs; s++) begin
        fwd_q[s].delete();
      end
      issued = 0;
      returned = 0;
      beat_cnt = 0;
      in_burst = 1'b0;
      ar_pending = 1'b0;
    end else begin
      if (ar_pending) begin
        assert (downstream_arvalid[pend_sub])
          else report_error("AR not forwarded one cycle after acceptance");
        assert (ar_entry(downstream_arid[pend_sub], downstream_araddr[pend_sub],
                         downstream_arlen[pend_sub], downstream_arsize[pend_sub],
                         downstream_arburst[pend_sub]) == pend_entry)
          else report_error("Forwarded AR fields differ from the request");
        ar_pending = 1'b0;
      end
      for (int s = 0; s < num_subs; s++) begin
        if (downstream_arvalid[s] && downstream_arready[s]) begin
          assert (fwd_q[s].size() > 0)
            else report_error("Subordinate got an AR that was not sent to it");
          entry = fwd_q[s].pop_front();
          assert (ar_entry(downstream_arid[s], downstream_araddr[s], downstream_arlen[s],
                           downstream_arsize[s], downstream_arburst[s]) == entry)
            else report_error("Downstream AR does not match the expected request");
        end
      end
      if (arvalid && arready) begin
        // A busy ID may only stack onto its owner up to the cap.
        assert (outstanding[arid] == 0 ||
                (owner[arid] == ar_sub_select && outstanding[arid] < max_outstanding))
          else report_error("Read accepted while its ID was blocked");
        pend_entry = ar_entry(arid, araddr, arlen, arsize, arburst);
        pend_sub = int'(ar_sub_select);
        ar_pending = 1'b1;
        fwd_q[pend_sub].push_back(pend_entry);
        exp_q[arid].push_back(32'({arlen, araddr}));
        outstanding[arid]++;
        owner[arid] = ar_sub_select;
        issued++;
      end
      if (rvalid && rready) begin
        assert (!in_burst || rid == burst_id)
          else report_error("Read bursts interleaved on the upstream R channel");
        assert (exp_q[rid].size() > 0) else report_error("Read data for an ID with no read");
        entry = exp_q[rid][0];
        assert (rdata == 32'(entry[11:0]) + 32'(beat_cnt))
          else report_error("Wrong read data");
        assert (rresp == 2'(resp_okay)) else report_error("Wrong read response");
        assert (rlast == (beat_cnt == int'(entry[19:12])))
          else report_error("Last flag on the wrong beat");
        if (rlast) begin
          void'(exp_q[rid].pop_front());
          outstanding[rid]--;
          returned++;
          in_burst = 1'b0;
          beat_cnt = 0;
        end else begin
          in_burst = 1'b1;
          burst_id = rid;
          beat_cnt++;
        end
      end
    end
  end

  // Subordinate state advances on handshakes.
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < num_subs; s++) begin
        sub_q[s].delete();
        beat_idx[s] = 0;
      end
    end else begin
      for (int s = 0; s < num_subs; s++) begin
        if (downstream_rvalid[s] && downstream_rready[s]) begin
          if (downstream_rlast[s]) begin
            void'(sub_q[s].pop_front());
            beat_idx[s] = 0;
          end else begin
            beat_idx[s]++;
          end
        end
        if (downstream_arvalid[s] && downstream_arready[s]) begin
          sub_q[s].push_back(32'({downstream_arid[s], downstream_arlen[s],
                                  downstream_araddr[s]}));
        end
      end
    end
  end

  // Subordinate outputs and random ready gaps driven on the falling edge.
  initial begin
    logic [31:0] entry;
    downstream_rvalid = '0;
    downstream_rid = '0;
    downstream_rdata = '0;
    downstream_rresp = '0;
    downstream_rlast = '0;
    downstream_arready = '0;
    rready = 1'b0;
    ready_lcg = seed;
    forever begin
      @(negedge clk);
      ready_lcg = lcg_next(ready_lcg);
      rready = (ready_lcg[17:16] != 2'b00);
      for (int s = 0; s < num_subs; s++) begin
        downstream_arready[s] = !ar_gaps || ready_lcg[24+s];
        if (rst_n && !hold[s] && sub_q[s].size() > 0) begin
          entry = sub_q[s][0];
          downstream_rvalid[s] = 1'b1;
          downstream_rid[s] = entry[21:20];
          downstream_rdata[s] = 32'(entry[11:0]) + 32'(beat_idx[s]);
          downstream_rresp[s] = 2'(resp_okay);
          downstream_rlast[s] = (beat_idx[s] == int'(entry[19:12]));
        end else begin
          downstream_rvalid[s] = 1'b0;
          downstream_rlast[s] = 1'b0;
        end
      end
    end
  end

  task automatic set_hold(input int s, input logic value);
    @(posedge clk);
    hold[s] = value;
  endtask

  task automatic present_read(input int sub, input int id, input logic [addr_width-1:0] addr,
                              input logic [len_width-1:0] len);
    @(negedge clk);
    ar_sub_select = 1'(sub);
    arid = id_width'(id);
    araddr = addr;
    arlen = len;
    arsize = 3'd2 + 3'(addr[0]);
    arburst = addr[1] ? 2'b01 : 2'b10;
    arvalid = 1'b1;
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!arready) begin
      cycles++;
      if (cycles > timeout_cycles) timeout_abort("upstream arready");
      @(posedge clk);
    end
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic issue_read(input int sub, input int id, input logic [addr_width-1:0] addr,
                            input logic [len_width-1:0] len);
    present_read(sub, id, addr, len);
    wait_accept();
  endtask

  task automatic expect_stall(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      assert (!arready) else report_error("Blocked read was accepted");
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (issued != returned) begin
      cycles++;
      if (cycles > timeout_cycles) timeout_abort("outstanding reads to return");
      @(negedge clk);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    ar_sub_select = '0;
    araddr = '0;
    arid = '0;
    arlen = '0;
    arsize = '0;
    arburst = '0;
    arvalid = 1'b0;
    hold = '0;
    ar_gaps = 1'b0;
    traffic_lcg = seed;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    assert (downstream_arvalid == '0 && !rvalid)
      else report_error("Valid outputs not low after reset");

    // Same ID on another subordinate waits for the first burst to finish.
    set_hold(0, 1'b1);
    issue_read(0, 1, 12'h100, 8'd3);
    present_read(1, 1, 12'h200, 8'd1);
    expect_stall(12);
    set_hold(0, 1'b0);
    wait_accept();
    wait_idle();

    // Three reads per ID may be in flight and a fourth waits.
    set_hold(1, 1'b1);
    for (int n = 0; n < 3; n++) begin
      issue_read(1, 2, 12'h300 + 12'(n * 16), 8'(n));
    end
    present_read(1, 2, 12'h400, 8'd2);
    expect_stall(12);
    set_hold(1, 1'b0);
    wait_accept();
    wait_idle();

    // Random traffic with gaps on downstream arready and upstream rready.
    ar_gaps = 1'b1;
    for (int n = 0; n < 40; n++) begin
      traffic_lcg = lcg_next(traffic_lcg);
      issue_read(int'(traffic_lcg[16]), int'(traffic_lcg[18:17]), traffic_lcg[31:20],
                 8'(traffic_lcg[20:19]));
    end
    wait_idle();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
axi_demux_pkg.sv
ar_chan_if.sv
r_chan_if.sv
id_order_tracker.sv
ar_router.sv
r_burst_arbiter.sv
axi_read_demux.sv
tb_axi_read_demux.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI read demux testbench with Verilator.

cd "$(dirname "$0")" || exit 1
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_axi_read_demux -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_axi_read_demux > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Simulation FAILED" "$log"; then
  echo "Testbench reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Run completed without failures"
exit 0
